/* decode_golden.txt */
// instr    pc       ctl      dst      imm      br_target jump_target
// ctl packs alu_funct..likely as in control_t, dst is zero extended
00221820 00400000 00002712 00000003 00001820 00406084 00886080
00a62023 00400004 00082702 00000004 00002023 00408094 0298808c
000838c0 00400008 00322702 00000007 000038c0 0040e30c 0020e300
014b482a 0040000c 00082442 00000009 0000482a 004120b8 052d20a8
01802809 00400010 0079bfc2 00000005 00002809 0040a038 0600a024
00000001 00400014 007fe720 00000000 00000001 0040001c 00000004
2022ffff 00400018 00008712 00000002 ffffffff 00400018 008bfffc
34838001 0040001c 00188702 00000003 00008001 003e0024 020e0004
3c051234 00400020 004e8702 00000005 12340000 004048f4 001448d0
2ce60005 00400024 00088542 00000006 00000005 0040003c 03980014
10220004 00400028 00786800 00000000 00000004 0040003c 00880010
5460fffe 0040002c 00786901 00000000 fffffffe 00400028 0183fff8
04910010 00400030 0079cec2 0000001f 00000010 00400074 02440040
04a00008 00400034 0079ec00 00000000 00000008 00400058 02800020
04020000 00400038 007fe720 00000000 00000000 0040003c 00080000
0c100040 a0000100 007fd7c2 0000001f 00000040 a0000204 a0400100
08ffffff 10000ffc 007ff700 00000000 ffffffff 10000ffc 13fffffc
8fa8fff8 00400040 0000878a 00000008 fffffff8 00400024 0ea3ffe0
afa9000c 00400044 0000e704 00000000 0000000c 00400078 0ea40030
fc001234 00400048 007fe720 00000000 00001234 0040491c 000048d0

/* build.f */
mips_isa_pkg.sv
ctrl_pkg.sv
rtype_decoder.sv
regimm_decoder.sv
main_decoder.sv
operand_extender.sv
decode_stage.sv
decode_stage_props.sv
tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_decode_stage -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Compilation failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

/* tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int NUM_VECTORS  = 20;
    localparam int VECTOR_WORDS = 7;
    localparam int WAIT_LIMIT   = 200;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    word_t    in_instr;
    word_t    in_pc;
    logic     out_valid;
    logic     out_ready = 1'b1;
    decoded_t out_bundle;

    word_t       golden_mem [0:NUM_VECTORS*VECTOR_WORDS-1];
    int          pending_idx_q[$];
    int          pending_cycle_q[$];
    int          sent_idx;
    int          cycle_count;
    int          error_count;
    int          check_count;
    logic        strict_timing;
    logic        random_ready;
    logic        timed_out;
    logic [15:0] lfsr_state;

    decode_stage decode_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .in_pc      (in_pc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    bind decode_stage decode_stage_props decode_stage_props_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("** Error %s: got 0x%h expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    // Each record holds instr, pc, ctl, dst, imm, branch_target and jump_target.
    task automatic check_bundle(input int idx);
        word_t instr;
        int    base;
        base  = idx * VECTOR_WORDS;
        instr = golden_mem[base];
        check_value("ctl", {9'd0, out_bundle.ctl}, golden_mem[base+2]);
        check_value("rs", {27'd0, out_bundle.rs}, {27'd0, instr[25:21]});
        check_value("rt", {27'd0, out_bundle.rt}, {27'd0, instr[20:16]});
        check_value("dst", {27'd0, out_bundle.dst}, golden_mem[base+3]);
        check_value("shamt", {27'd0, out_bundle.shamt}, {27'd0, instr[10:6]});
        check_value("imm", out_bundle.imm, golden_mem[base+4]);
        check_value("branch_target", out_bundle.branch_target, golden_mem[base+5]);
        check_value("jump_target", out_bundle.jump_target, golden_mem[base+6]);
        check_value("pc", out_bundle.pc, golden_mem[base+1]);
    endtask

    // Back-pressure from the execute side.
    always @(posedge clk) begin
        if (random_ready) begin
            lfsr_state = lfsr_step(lfsr_state);
            out_ready <= lfsr_state[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Scoreboard sampled on the edge that makes the transfers.
    always @(posedge clk) begin
        int idx;
        int cyc;
        if (arst_n) begin
            cycle_count++;
            if (out_valid && out_ready) begin
                if (pending_idx_q.size() == 0) begin
                    $display("Output bundle arrived with no input pending");
                    error_count++;
                end else begin
                    idx = pending_idx_q.pop_front();
                    cyc = pending_cycle_q.pop_front();
                    check_bundle(idx);
                    if (strict_timing)
                        check_value("latency", 32'(cycle_count - cyc), 32'd1);
                end
            end
            if (in_valid && in_ready) begin
                pending_idx_q.push_back(sent_idx);
                pending_cycle_q.push_back(cycle_count);
            end
            if (strict_timing && in_valid && !in_ready) begin
                $display("Input stalled although out_ready was held high");
                error_count++;
            end
        end
    end

    task automatic send_vector(input int idx);
        int waited;
        waited   = 0;
        in_valid <= 1'b1;
        in_instr <= golden_mem[idx*VECTOR_WORDS];
        in_pc    <= golden_mem[idx*VECTOR_WORDS+1];
        sent_idx <= idx;
        @(posedge clk);
        while (!in_ready && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: input %0d was never accepted", idx);
                error_count++;
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    // The queue is looked at between edges, after the scoreboard has run.
    task automatic drain_outputs();
        int waited;
        waited   = 0;
        in_valid <= 1'b0;
        @(negedge clk);
        while (pending_idx_q.size() != 0 && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: %0d bundles never left the stage", pending_idx_q.size());
                error_count++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_pc         = '0;
        sent_idx      = 0;
        cycle_count   = 0;
        error_count   = 0;
        check_count   = 0;
        strict_timing = 1'b0;
        random_ready  = 1'b0;
        timed_out     = 1'b0;
        lfsr_state    = 16'd31484;
        $readmemh("decode_golden.txt", golden_mem);

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("out_valid", {31'd0, out_valid}, 32'd0);
        check_value("in_ready", {31'd0, in_ready}, 32'd1);

        // ~~~~~~~~~~~~~~~~~~~~
        // Full rate
        // ~~~~~~~~~~~~~~~~~~~~
        strict_timing <= 1'b1;
        for (int i = 0; i < NUM_VECTORS && !timed_out; i++)
            send_vector(i);
        drain_outputs();
        @(posedge clk);
        strict_timing <= 1'b0;

        // ~~~~~~~~~~~~~~~~~~~~
        // Back-pressure
        // ~~~~~~~~~~~~~~~~~~~~
        random_ready <= 1'b1;
        for (int i = 0; i < NUM_VECTORS && !timed_out; i++) begin
            send_vector(i);
            // An idle cycle now and then.
            if (i % 3 == 2) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
        end
        drain_outputs();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* decode_stage_props.sv */
`default_nettype none

module decode_stage_props (
    input logic               clk,
    input logic               arst_n,
    input logic               out_valid,
    input logic               out_ready,
    input ctrl_pkg::decoded_t out_bundle
);
    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    // Empty output register coming out of reset.
    assert property (@(posedge clk) !arst_n |=> !out_valid)
        else $error("out_valid high after reset");

    // A stalled bundle must hold.
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle))
        else $error("stalled bundle changed or dropped");

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_bundle.ctl.exc_chk == EXC_RESERVED
            |-> !out_bundle.ctl.write_reg && !out_bundle.ctl.mem_write)
        else $error("reserved instruction writes state");

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  mips_isa_pkg::word_t in_instr,
    input  mips_isa_pkg::word_t in_pc,
    output logic                out_valid,
    input  logic                out_ready,
    output ctrl_pkg::decoded_t  out_bundle
);
    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    instr_fields_t fields;
    control_t      ctl;
    imm_kind_e     imm_kind;
    word_t         imm;
    word_t         branch_target;
    word_t         jump_target;
    reg_idx_t      dst;

    assign fields = instr_fields_t'(in_instr);

    main_decoder main_decoder_i (
        .instruction (in_instr),
        .ctl         (ctl),
        .imm_kind    (imm_kind)
    );

    operand_extender operand_extender_i (
        .instruction   (in_instr),
        .pc            (in_pc),
        .imm_kind      (imm_kind),
        .imm           (imm),
        .branch_target (branch_target),
        .jump_target   (jump_target)
    );

    always_comb begin
        case (ctl.dest_reg)
            DEST_RT: dst = fields.rt;
            DEST_RD: dst = fields.rd;
            DEST_RA: dst = REG_RA;
            default: dst = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~

    // Accept when empty or when the held bundle leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_bundle <= '{ctl: ctl, rs: fields.rs, rt: fields.rt, dst: dst,
                            shamt: fields.shamt, imm: imm,
                            branch_target: branch_target, jump_target: jump_target,
                            pc: in_pc};
        end
    end

endmodule

`default_nettype wire

/* operand_extender.sv */
`default_nettype none

module operand_extender (
    input  mips_isa_pkg::word_t instruction,
    input  mips_isa_pkg::word_t pc,
    input  ctrl_pkg::imm_kind_e imm_kind,
    output mips_isa_pkg::word_t imm,
    output mips_isa_pkg::word_t branch_target,
    output mips_isa_pkg::word_t jump_target
);
    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    word_t sign_imm;
    word_t pc_plus4;

    assign sign_imm = {{16{instruction[15]}}, instruction[15:0]};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (imm_kind)
            IMM_ZERO:  imm = {16'h0000, instruction[15:0]};
            IMM_UPPER: imm = {instruction[15:0], 16'h0000};
            default:   imm = sign_imm;
        endcase
    end

    // Offsets count words from the delay slot.
    assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instruction[25:0], 2'b00};

endmodule

`default_nettype wire

/* main_decoder.sv */
`default_nettype none

module main_decoder (
    input  mips_isa_pkg::word_t  instruction,
    output ctrl_pkg::control_t   ctl,
    output ctrl_pkg::imm_kind_e  imm_kind
);
    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    instr_fields_t fields;
    control_t      rtype_ctl;
    control_t      regimm_ctl;

    assign fields = instr_fields_t'(instruction);

    rtype_decoder rtype_decoder_i (
        .instruction (instruction),
        .ctl         (rtype_ctl)
    );

    regimm_decoder regimm_decoder_i (
        .instruction (instruction),
        .ctl         (regimm_ctl)
    );

    always_comb begin
        ctl      = CTL_DEFAULT;
        imm_kind = IMM_SIGN;
        case (fields.opcode)
            OP_RTYPE:  ctl = rtype_ctl;
            OP_REGIMM: ctl = regimm_ctl;

            OP_J, OP_JAL: begin
                ctl.pc_src = PC_JUMP;
                if (fields.opcode == OP_JAL) begin
                    ctl.dest_reg  = DEST_RA;
                    ctl.reg_src   = REG_SRC_PCADD8;
                    ctl.write_reg = 1'b1;
                end
            end

            // ~~~~~~~~~~~~~~~~~~~~
            // Compare branches
            // ~~~~~~~~~~~~~~~~~~~~
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
            OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL: begin
                ctl.pc_src   = PC_BRANCH;
                ctl.alu_srca = SRCA_RS;
                ctl.alu_srcb = SRCB_RT;
                case (fields.opcode)
                    OP_BEQ, OP_BEQL:   ctl.flag_sel = FLAG_EQ;
                    OP_BNE, OP_BNEL:   ctl.flag_sel = FLAG_NE;
                    OP_BLEZ, OP_BLEZL: ctl.flag_sel = FLAG_LE;
                    default:           ctl.flag_sel = FLAG_GT;
                endcase
                // The likely forms sit sixteen codes above the plain ones.
                ctl.likely = fields.opcode[4];
            end

            // ~~~~~~~~~~~~~~~~~~~~
            // Immediate ALU ops
            // ~~~~~~~~~~~~~~~~~~~~
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctl.alu_srca  = SRCA_RS;
                ctl.alu_srcb  = SRCB_IMMED;
                ctl.dest_reg  = DEST_RT;
                ctl.write_reg = 1'b1;
                case (fields.opcode)
                    OP_ADDI, OP_ADDIU: begin
                        ctl.alu_funct = ALU_ADD;
                        if (fields.opcode == OP_ADDI)
                            ctl.exc_chk = EXC_OVERFLOW;
                    end
                    OP_SLTI, OP_SLTIU: begin
                        ctl.alu_funct = ALU_SUB;
                        ctl.reg_src   = REG_SRC_FLAG;
                        ctl.flag_sel  = (fields.opcode == OP_SLTI) ? FLAG_LT : FLAG_LTU;
                    end
                    OP_ANDI: ctl.alu_funct = ALU_AND;
                    OP_ORI:  ctl.alu_funct = ALU_OR;
                    OP_XORI: ctl.alu_funct = ALU_XOR;
                    default: begin
                        ctl.alu_funct = ALU_LUI;
                        ctl.alu_srca  = SRCA_NCARE;
                    end
                endcase
                if (fields.opcode inside {OP_ANDI, OP_ORI, OP_XORI})
                    imm_kind = IMM_ZERO;
                else if (fields.opcode == OP_LUI)
                    imm_kind = IMM_UPPER;
            end

            OP_LW, OP_SW: begin
                ctl.alu_funct = ALU_ADD;
                ctl.alu_srca  = SRCA_RS;
                ctl.alu_srcb  = SRCB_IMMED;
                if (fields.opcode == OP_LW) begin
                    ctl.mem_read  = 1'b1;
                    ctl.reg_src   = REG_SRC_MEM;
                    ctl.dest_reg  = DEST_RT;
                    ctl.write_reg = 1'b1;
                end else begin
                    ctl.mem_write = 1'b1;
                end
            end

            default:
                ctl.exc_chk = EXC_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

/* regimm_decoder.sv */
`default_nettype none

module regimm_decoder (
    input  mips_isa_pkg::word_t instruction,
    output ctrl_pkg::control_t  ctl
);
    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    instr_fields_t fields;
    regimm_e       code;

    assign fields = instr_fields_t'(instruction);
    assign code   = regimm_e'(fields.rt);

    // Branches compare rs against zero.
    always_comb begin
        ctl = CTL_DEFAULT;
        case (code)
            RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL: begin
                ctl.pc_src   = PC_BRANCH;
                ctl.alu_srca = SRCA_RS;
                if (code == RI_BLTZ || code == RI_BLTZAL)
                    ctl.flag_sel = FLAG_LT;
                else
                    ctl.flag_sel = FLAG_GE;
                if (code == RI_BLTZAL || code == RI_BGEZAL) begin
                    ctl.dest_reg  = DEST_RA;
                    ctl.reg_src   = REG_SRC_PCADD8;
                    ctl.write_reg = 1'b1;
                end
            end

            default:
                ctl.exc_chk = EXC_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

/* rtype_decoder.sv */
`default_nettype none

module rtype_decoder (
    input  mips_isa_pkg::word_t instruction,
    output ctrl_pkg::control_t  ctl
);
    import mips_isa_pkg::*;
    import ctrl_pkg::*;

    instr_fields_t fields;

    assign fields = instr_fields_t'(instruction);

    always_comb begin
        ctl = CTL_DEFAULT;
        case (fields.funct)
            FN_SLL, FN_SRL, FN_SRA: begin
                ctl.alu_srca  = SRCA_SHAMT;
                ctl.alu_srcb  = SRCB_RT;
                ctl.dest_reg  = DEST_RD;
                ctl.write_reg = 1'b1;
                case (fields.funct)
                    FN_SLL:  ctl.alu_funct = ALU_SLL;
                    FN_SRL:  ctl.alu_funct = ALU_SRL;
                    default: ctl.alu_funct = ALU_SRA;
                endcase
            end

            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
            FN_AND, FN_OR, FN_XOR, FN_NOR,
            FN_SLT, FN_SLTU: begin
                ctl.alu_srca  = SRCA_RS;
                ctl.alu_srcb  = SRCB_RT;
                ctl.dest_reg  = DEST_RD;
                ctl.write_reg = 1'b1;
                case (fields.funct)
                    FN_ADD, FN_ADDU: ctl.alu_funct = ALU_ADD;
                    FN_AND:          ctl.alu_funct = ALU_AND;
                    FN_OR:           ctl.alu_funct = ALU_OR;
                    FN_XOR:          ctl.alu_funct = ALU_XOR;
                    FN_NOR:          ctl.alu_funct = ALU_NOR;
                    default:         ctl.alu_funct = ALU_SUB;
                endcase
                if (fields.funct == FN_ADD || fields.funct == FN_SUB)
                    ctl.exc_chk = EXC_OVERFLOW;
                // Set-on-less-than writes the comparison flag.
                if (fields.funct == FN_SLT || fields.funct == FN_SLTU) begin
                    ctl.reg_src  = REG_SRC_FLAG;
                    ctl.flag_sel = (fields.funct == FN_SLT) ? FLAG_LT : FLAG_LTU;
                end
            end

            FN_JR, FN_JALR: begin
                ctl.pc_src   = PC_JREG;
                ctl.alu_srca = SRCA_RS;
                if (fields.funct == FN_JALR) begin
                    ctl.dest_reg  = DEST_RD;
                    ctl.reg_src   = REG_SRC_PCADD8;
                    ctl.write_reg = 1'b1;
                end
            end

            default:
                ctl.exc_chk = EXC_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Selectors
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_NCARE = 4'hf
    } alu_funct_e;

    typedef enum logic [1:0] {SRCA_RS, SRCA_SHAMT, SRCA_NCARE = 2'd3} alu_srca_e;

    typedef enum logic [1:0] {SRCB_RT, SRCB_IMMED, SRCB_NCARE = 2'd3} alu_srcb_e;

    typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA, DEST_NCARE} dest_reg_e;

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_JREG} pc_src_e;

    typedef enum logic [2:0] {
        FLAG_EQ, FLAG_NE, FLAG_LE, FLAG_GT, FLAG_LT, FLAG_LTU, FLAG_GE, FLAG_NCARE
    } flag_sel_e;

    typedef enum logic [1:0] {
        REG_SRC_ALU, REG_SRC_FLAG, REG_SRC_MEM, REG_SRC_PCADD8
    } reg_src_e;

    // Check the execute stage has to make before committing.
    typedef enum logic [1:0] {EXC_NONE, EXC_OVERFLOW, EXC_RESERVED} exc_chk_e;

    typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bundles
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        alu_funct_e alu_funct;
        alu_srca_e  alu_srca;
        alu_srcb_e  alu_srcb;
        dest_reg_e  dest_reg;
        pc_src_e    pc_src;
        flag_sel_e  flag_sel;
        reg_src_e   reg_src;
        exc_chk_e   exc_chk;
        logic       mem_read;
        logic       mem_write;
        logic       write_reg;
        logic       likely;
    } control_t;

    // Word every decoder starts from.
    localparam control_t CTL_DEFAULT = '{
        alu_funct: ALU_NCARE,
        alu_srca:  SRCA_NCARE,
        alu_srcb:  SRCB_NCARE,
        dest_reg:  DEST_NCARE,
        pc_src:    PC_NEXT,
        flag_sel:  FLAG_NCARE,
        reg_src:   REG_SRC_ALU,
        exc_chk:   EXC_NONE,
        mem_read:  1'b0,
        mem_write: 1'b0,
        write_reg: 1'b0,
        likely:    1'b0
    };

    typedef struct packed {
        control_t              ctl;
        mips_isa_pkg::reg_idx_t rs;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::reg_idx_t dst;
        mips_isa_pkg::shamt_t  shamt;
        mips_isa_pkg::word_t   imm;
        mips_isa_pkg::word_t   branch_target;
        mips_isa_pkg::word_t   jump_target;
        mips_isa_pkg::word_t   pc;
    } decoded_t;

endpackage

`default_nettype wire

/* mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;

    // Link register written by JAL and the AL branches.
    localparam reg_idx_t REG_RA = 5'd31;

    // ~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        OP_RTYPE  = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ    = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI   = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI   = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_BEQL   = 6'h14, OP_BNEL   = 6'h15, OP_BLEZL = 6'h16, OP_BGTZL = 6'h17,
        OP_LW     = 6'h23, OP_SW     = 6'h2b
    } opcode_e;

    // SPECIAL function codes.
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA = 6'h03,
        FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // REGIMM codes live in the rt field.
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    // R-type view of an instruction word that also covers I and J words by bit range.
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   shamt;
        funct_e   funct;
    } instr_fields_t;

endpackage

`default_nettype wire
